/* compile.f */
+incdir+rtl
rtl/engine_pkg.sv
rtl/engine_config_regs.sv
rtl/engine_read_write_kernel.sv
rtl/engine_buffer_memory.sv
rtl/engine_read_write_top.sv
tb/tb_clock_gen.sv
tb/tb_engine_read_write.sv

/* rtl/engine_buffer_memory.sv */
// Single-port word buffer that performs the write or read carried by each kernel request
`include "engine_defs.svh"

module engine_buffer_memory (
  input  logic                       ap_clk,
  input  logic                       rst_n,
  input  logic                       req_valid,
  input  engine_pkg::mem_request_t   request,
  output logic                       resp_valid,
  output logic [`ENGINE_FIELD_W-1:0] rd_data
);

  import engine_pkg::*;

  // --------------------------------------------------
  // Storage and address
  // --------------------------------------------------

  // Cleared by reset so unwritten words read as zero
  logic [`ENGINE_FIELD_W-1:0] mem [`ENGINE_MEM_DEPTH];

  // Word address from the low offset bits
  logic [`ENGINE_MEM_AW-1:0]  addr;

  // Qualified strobes
  logic                       wr_en;
  logic                       rd_en;

  assign addr  = request.offset[`ENGINE_MEM_AW-1:0];
  assign wr_en = req_valid && request.write_mode;
  assign rd_en = req_valid && !request.write_mode;

  // --------------------------------------------------
  // Write port
  // --------------------------------------------------

  // Write lands on the same edge as the request
  always_ff @(posedge ap_clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < `ENGINE_MEM_DEPTH; k++) begin
        mem[k] <= '0;
      end
    end else if (wr_en) begin
      mem[addr] <= request.wdata;
    end
  end

  // --------------------------------------------------
  // Read port
  // --------------------------------------------------

  // Read data one cycle after the request
  always_ff @(posedge ap_clk) begin
    if (rd_en) begin
      rd_data <= mem[addr];
    end
  end

  // Writes give no response
  always_ff @(posedge ap_clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_valid <= 1'b0;
    end else begin
      resp_valid <= rd_en;
    end
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // Kernel offset must already fit the buffer, no silent wrap
  a_offset_in_range : assert property (
    @(posedge ap_clk) disable iff (!rst_n)
    req_valid |-> (request.offset[`ENGINE_FIELD_W-1:`ENGINE_MEM_AW] == '0)
  ) else $error("request offset 0x%08h outside buffer", request.offset);

endmodule : engine_buffer_memory

/* rtl/engine_config_regs.sv */
// Configuration register block; decodes strobed writes into the kernel's live configuration
`include "engine_defs.svh"

module engine_config_regs (
  input  logic                   ap_clk,
  input  logic                   rst_n,
  input  logic                   cfg_we,
  input  logic [1:0]             cfg_addr,
  input  engine_pkg::cfg_word_u  cfg_wdata,
  output engine_pkg::rw_config_t config_params
);

  import engine_pkg::*;

  // --------------------------------------------------
  // Register storage
  // --------------------------------------------------

  // Control fields as last written at address 0
  cfg_ctrl_word_t             ctrl_q;

  // Constant for forced lanes
  logic [`ENGINE_FIELD_W-1:0] const_q;

  // Base index added to lane 1
  logic [`ENGINE_FIELD_W-1:0] index_q;

  // --------------------------------------------------
  // Write decode
  // --------------------------------------------------

  // Address 0 goes through the control view,
  // addresses 1 and 2 through the value view
  always_ff @(posedge ap_clk or negedge rst_n) begin
    if (!rst_n) begin
      ctrl_q  <= '0;
      const_q <= '0;
      index_q <= '0;
    end else if (cfg_we) begin
      case (cfg_addr)
        `ENGINE_CFG_ADDR_CTRL: begin
          ctrl_q <= cfg_wdata.ctrl_word;
        end
        `ENGINE_CFG_ADDR_CONST: begin
          const_q <= cfg_wdata.value_word;
        end
        `ENGINE_CFG_ADDR_INDEX: begin
          index_q <= cfg_wdata.value_word;
        end
        default: begin
          // Unmapped address, write is dropped
        end
      endcase
    end
  end

  // --------------------------------------------------
  // Live configuration out
  // --------------------------------------------------

  // Plain level into the kernel, held between writes
  always_comb begin
    config_params.ops_mask    = ctrl_q.ops_mask;
    config_params.const_mask  = ctrl_q.const_mask;
    config_params.const_value = const_q;
    config_params.index_start = index_q;
    config_params.granularity = ctrl_q.granularity;
    config_params.direction   = ctrl_q.direction;
    config_params.write_mode  = ctrl_q.write_mode;
    config_params.id_channel  = ctrl_q.id_channel;
    // Three-bit tag widened to the request tag
    config_params.id_buffer   = {1'b0, ctrl_q.id_buffer};
    config_params.pad         = '0;
  end

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  // Software must only target the three mapped registers
  a_cfg_addr_mapped : assert property (
    @(posedge ap_clk) disable iff (!rst_n)
    cfg_we |-> (cfg_addr < 2'd3)
  ) else $error("config write to unmapped address %0d", cfg_addr);

endmodule : engine_config_regs

/* rtl/engine_defs.svh */
// Size and register-map defines for the read/write engine, included by package and RTL
`ifndef ENGINE_DEFS_SVH
`define ENGINE_DEFS_SVH

// --------------------------------------------------
// Packet geometry
// --------------------------------------------------

// Fields carried by one engine packet
`define ENGINE_NUM_FIELDS 4

// Width of each field, also the buffer word width
`define ENGINE_FIELD_W 32

// --------------------------------------------------
// Buffer memory
// --------------------------------------------------

// Words in the local buffer
`define ENGINE_MEM_DEPTH 256

// Address bits taken from the low end of the offset
`define ENGINE_MEM_AW 8

// --------------------------------------------------
// Configuration register addresses
// --------------------------------------------------
`define ENGINE_CFG_ADDR_CTRL  2'd0
`define ENGINE_CFG_ADDR_CONST 2'd1
`define ENGINE_CFG_ADDR_INDEX 2'd2

`endif

/* rtl/engine_pkg.sv */
// Shared packet, configuration, request and config-word types for the read/write engine
`include "engine_defs.svh"

package engine_pkg;

  // --------------------------------------------------
  // Data packet
  // --------------------------------------------------

  // Four 32-bit fields, field[0] in the low bits
  typedef struct packed {
    logic [`ENGINE_NUM_FIELDS-1:0][`ENGINE_FIELD_W-1:0] field;
  } engine_packet_t;

  // --------------------------------------------------
  // Live configuration, 107 bits
  // --------------------------------------------------

  // ops_mask[i][j] routes input field j into lane i
  typedef struct packed {
    logic [`ENGINE_NUM_FIELDS-1:0][`ENGINE_NUM_FIELDS-1:0] ops_mask;
    logic [`ENGINE_NUM_FIELDS-1:0] const_mask;
    logic [`ENGINE_FIELD_W-1:0]    const_value;
    logic [`ENGINE_FIELD_W-1:0]    index_start;
    logic [2:0]                    granularity;
    logic                          direction;    // 1 = shift left
    logic                          write_mode;
    logic [3:0]                    id_channel;
    logic [3:0]                    id_buffer;
    logic [9:0]                    pad;
  } rw_config_t;

  // --------------------------------------------------
  // Buffer request, burst length fixed at one
  // --------------------------------------------------
  typedef struct packed {
    logic [`ENGINE_FIELD_W-1:0] offset;
    logic [2:0]                 shift_amount;
    logic                       shift_direction;
    logic                       write_mode;
    logic [3:0]                 id_channel;
    logic [3:0]                 id_buffer;
    logic [`ENGINE_FIELD_W-1:0] wdata;
  } mem_request_t;

  // --------------------------------------------------
  // Configuration write word
  // --------------------------------------------------

  // Control layout, exactly 32 bits
  // Buffer tag only gets three bits here, the top tag bit reads as zero
  typedef struct packed {
    logic [`ENGINE_NUM_FIELDS-1:0][`ENGINE_NUM_FIELDS-1:0] ops_mask;
    logic [`ENGINE_NUM_FIELDS-1:0] const_mask;
    logic [2:0]                    granularity;
    logic                          direction;
    logic                          write_mode;
    logic [3:0]                    id_channel;
    logic [2:0]                    id_buffer;
  } cfg_ctrl_word_t;

  // Same write word, seen as control fields or as a plain value
  typedef union packed {
    cfg_ctrl_word_t             ctrl_word;
    logic [`ENGINE_FIELD_W-1:0] value_word;
  } cfg_word_u;

endpackage : engine_pkg

/* rtl/engine_read_write_kernel.sv */
// Three-stage field router and address generator feeding the buffer with one request per packet
`include "engine_defs.svh"

module engine_read_write_kernel (
  input  logic                       ap_clk,
  input  logic                       rst_n,
  input  engine_pkg::rw_config_t     config_params,
  input  logic                       in_valid,
  input  engine_pkg::engine_packet_t data_in,
  output logic                       req_valid,
  output engine_pkg::mem_request_t   request,
  output engine_pkg::engine_packet_t result
);

  import engine_pkg::*;

  // Stage 1 lanes, forced and unforced
  engine_packet_t             ops_lanes_d;
  engine_packet_t             org_lanes_d;
  engine_packet_t             ops_lanes_q;
  engine_packet_t             org_lanes_q;

  // Stage 2 request and carried result
  logic [`ENGINE_FIELD_W-1:0] offset_base;
  mem_request_t               request_d;
  mem_request_t               request_q;
  engine_packet_t             org_data_q;

  // Valid strobe alongside the three stages
  logic [2:0]                 valid_q;

  // --------------------------------------------------
  // Stage 1: lane routing
  // --------------------------------------------------

  // Later j overrides earlier, so the highest set bit wins
  // A lane with no routing bit set reads as zero
  always_comb begin
    for (int i = 0; i < `ENGINE_NUM_FIELDS; i++) begin
      org_lanes_d.field[i] = '0;
      for (int j = 0; j < `ENGINE_NUM_FIELDS; j++) begin
        if (config_params.ops_mask[i][j]) begin
          org_lanes_d.field[i] = data_in.field[j];
        end
      end
      // Forcing only affects the operand copy
      ops_lanes_d.field[i] = config_params.const_mask[i] ? config_params.const_value
                                                          : org_lanes_d.field[i];
    end
  end

  always_ff @(posedge ap_clk) begin
    ops_lanes_q <= ops_lanes_d;
    org_lanes_q <= org_lanes_d;
  end

  // --------------------------------------------------
  // Stage 2: address compute
  // --------------------------------------------------

  // Config sampled again here, as well as in stage 1
  always_comb begin
    offset_base = config_params.index_start + ops_lanes_q.field[1];
    if (config_params.direction) begin
      request_d.offset = offset_base << config_params.granularity;
    end else begin
      request_d.offset = offset_base >> config_params.granularity;
    end
    request_d.shift_amount    = config_params.granularity;
    request_d.shift_direction = config_params.direction;
    request_d.write_mode      = config_params.write_mode;
    request_d.id_channel      = config_params.id_channel;
    request_d.id_buffer       = config_params.id_buffer;
    // Write data is the unforced lane 0
    request_d.wdata           = org_lanes_q.field[0];
  end

  always_ff @(posedge ap_clk) begin
    request_q  <= request_d;
    org_data_q <= org_lanes_q;
  end

  // --------------------------------------------------
  // Stage 3: output registers
  // --------------------------------------------------
  always_ff @(posedge ap_clk) begin
    request <= request_q;
    result  <= org_data_q;
  end

  // Valid strobe travels beside the data stages
  always_ff @(posedge ap_clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      valid_q <= {valid_q[1:0], in_valid};
    end
  end

  assign req_valid = valid_q[2];

  // --------------------------------------------------
  // Checks
  // --------------------------------------------------

  a_in_valid_known : assert property (
    @(posedge ap_clk) disable iff (!rst_n)
    !$isunknown(in_valid)
  ) else $error("in_valid is unknown");

endmodule : engine_read_write_kernel

/* rtl/engine_read_write_top.sv */
// Top level of the read/write engine; joins configuration block, kernel and buffer memory
`include "engine_defs.svh"

module engine_read_write_top (
  input  logic                       ap_clk,
  input  logic                       rst_n,
  // Configuration write port
  input  logic                       cfg_we,
  input  logic [1:0]                 cfg_addr,
  input  engine_pkg::cfg_word_u      cfg_wdata,
  // Packet in
  input  logic                       in_valid,
  input  engine_pkg::engine_packet_t data_in,
  // Routed result out
  output logic                       result_valid,
  output engine_pkg::engine_packet_t result_out,
  // Read response from the buffer
  output logic                       resp_valid,
  output logic [`ENGINE_FIELD_W-1:0] rd_data
);

  import engine_pkg::*;

  // --------------------------------------------------
  // Internal wires
  // --------------------------------------------------

  // Live configuration level
  rw_config_t   config_params;

  // Kernel to buffer request
  mem_request_t request;

  // --------------------------------------------------
  // Configuration block
  // --------------------------------------------------
  engine_config_regs u_config_regs (
    .ap_clk        (ap_clk),
    .rst_n         (rst_n),
    .cfg_we        (cfg_we),
    .cfg_addr      (cfg_addr),
    .cfg_wdata     (cfg_wdata),
    .config_params (config_params)
  );

  // --------------------------------------------------
  // Kernel
  // --------------------------------------------------

  // Result strobe doubles as the request strobe
  engine_read_write_kernel u_kernel (
    .ap_clk        (ap_clk),
    .rst_n         (rst_n),
    .config_params (config_params),
    .in_valid      (in_valid),
    .data_in       (data_in),
    .req_valid     (result_valid),
    .request       (request),
    .result        (result_out)
  );

  // --------------------------------------------------
  // Buffer memory
  // --------------------------------------------------
  engine_buffer_memory u_buffer (
    .ap_clk     (ap_clk),
    .rst_n      (rst_n),
    .req_valid  (result_valid),
    .request    (request),
    .resp_valid (resp_valid),
    .rd_data    (rd_data)
  );

endmodule : engine_read_write_top

/* run_sim.sh */
#!/bin/sh
# Builds the engine testbench with Verilator and runs it; success only on the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f compile.f --top-module tb_engine_read_write \
  -o tb_engine_read_write \
  && ./obj_dir/tb_engine_read_write | tee /dev/stderr | grep -qF "*** TEST PASSED ***" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

/* tb/tb_clock_gen.sv */
// Testbench clock and reset source; 10 ns ap_clk, rst_n held low for the first 8 cycles
module tb_clock_gen (
  output logic ap_clk,
  output logic rst_n
);

  timeunit 1ns;
  timeprecision 100ps;

  // Free running 100 MHz clock
  initial begin
    ap_clk = 1'b0;
    forever #5 ap_clk = ~ap_clk;
  end

  // Release just after the 8th rising edge, clear of the edge itself
  initial begin
    rst_n = 1'b0;
    repeat (8) @(posedge ap_clk);
    #1 rst_n = 1'b1;
  end

endmodule : tb_clock_gen

/* tb/tb_engine_read_write.sv */
// Table-driven testbench for the read/write engine; model, timing checks and pass/fail verdict
`include "engine_defs.svh"

module tb_engine_read_write;

  timeunit 1ns;
  timeprecision 100ps;

  import engine_pkg::*;

  // 8 reset cycles, 16 rows of about 12 cycles, plus margin
  localparam int unsigned CYCLE_LIMIT = 8 + 16 * 12 + 100;
  localparam int          NUM_ROWS    = 16;

  // --------------------------------------------------
  // Table and expectation types
  // --------------------------------------------------

  // One stimulus row; fix selects fields set to fval, the rest are random
  typedef struct packed {
    logic        do_cfg;
    logic        burst;    // four packets on consecutive cycles
    logic [15:0] ops;
    logic [3:0]  cmask;
    logic [2:0]  gran;
    logic        dir;
    logic        wr;
    logic [7:0]  cval;
    logic [7:0]  idx;
    logic [3:0]  fix;
    logic [7:0]  fval;
    logic [7:0]  exp_off;  // hand-worked buffer address
  } stim_row_t;

  typedef struct packed {
    logic [31:0]    due;
    engine_packet_t pkt;
  } res_exp_t;

  typedef struct packed {
    logic [31:0] due;
    logic [31:0] data;
  } rd_exp_t;

  // Columns: do_cfg burst ops cmask gran dir wr cval idx fix fval exp_off
  stim_row_t stim_table [NUM_ROWS] = '{
    // No configuration yet, so read of address 0
    '{1'b0, 1'b0, 16'h0000, 4'h0, 3'd0, 1'b0, 1'b0, 8'h00, 8'h00, 4'h0, 8'h00, 8'h00},
    // Straight routing written unshifted then read back through a right shift
    '{1'b1, 1'b0, 16'h8421, 4'h0, 3'd0, 1'b0, 1'b1, 8'h00, 8'h10, 4'h2, 8'h05, 8'h15},
    '{1'b1, 1'b0, 16'h8421, 4'h0, 3'd1, 1'b0, 1'b0, 8'h00, 8'h20, 4'h2, 8'h0a, 8'h15},
    // Reversed lanes written by a left shift and read by a right shift
    '{1'b1, 1'b0, 16'h1248, 4'h0, 3'd2, 1'b1, 1'b1, 8'h00, 8'h03, 4'h4, 8'h04, 8'h1c},
    '{1'b1, 1'b0, 16'h1248, 4'h0, 3'd3, 1'b0, 1'b0, 8'h00, 8'h60, 4'h4, 8'h80, 8'h1c},
    // Highest set bit wins per lane; right shift to write and left shift to read
    '{1'b1, 1'b0, 16'hf3c6, 4'h0, 3'd3, 1'b0, 1'b1, 8'h00, 8'h00, 4'h8, 8'h40, 8'h08},
    '{1'b1, 1'b0, 16'hf3c6, 4'h0, 3'd2, 1'b1, 1'b0, 8'h00, 8'h00, 4'h8, 8'h02, 8'h08},
    // Lanes 0 and 1 forced to the constant with a new constant and base on read
    '{1'b1, 1'b0, 16'h8421, 4'h3, 3'd1, 1'b1, 1'b1, 8'h22, 8'h01, 4'h0, 8'h00, 8'h46},
    '{1'b1, 1'b0, 16'h8421, 4'h3, 3'd0, 1'b0, 1'b0, 8'h40, 8'h06, 4'h0, 8'h00, 8'h46},
    // Word never written
    '{1'b1, 1'b0, 16'h8421, 4'h2, 3'd0, 1'b0, 1'b0, 8'h7f, 8'h00, 4'h0, 8'h00, 8'h7f},
    // Unrouted lanes read zero; carry into bit 8 before shift
    '{1'b1, 1'b0, 16'h0420, 4'h0, 3'd7, 1'b0, 1'b1, 8'h00, 8'h80, 4'h2, 8'h80, 8'h02},
    // Overwrite so the newest word must come back
    '{1'b1, 1'b0, 16'h8421, 4'h0, 3'd0, 1'b0, 1'b1, 8'h00, 8'h10, 4'h2, 8'h05, 8'h15},
    '{1'b1, 1'b0, 16'h8421, 4'h0, 3'd0, 1'b0, 1'b0, 8'h00, 8'h10, 4'h2, 8'h05, 8'h15},
    // Back-to-back bursts
    '{1'b1, 1'b1, 16'h8421, 4'h0, 3'd0, 1'b0, 1'b1, 8'h00, 8'h40, 4'h2, 8'h00, 8'h40},
    '{1'b1, 1'b1, 16'h8421, 4'h0, 3'd0, 1'b0, 1'b0, 8'h00, 8'h40, 4'h2, 8'h00, 8'h40},
    // Widest left shift
    '{1'b1, 1'b0, 16'h8421, 4'h0, 3'd7, 1'b1, 1'b0, 8'h00, 8'h01, 4'h2, 8'h00, 8'h80}
  };

  // --------------------------------------------------
  // DUT signals and model state
  // --------------------------------------------------
  logic           ap_clk;
  logic           rst_n;
  logic           cfg_we;
  logic [1:0]     cfg_addr;
  cfg_word_u      cfg_wdata;
  logic           in_valid;
  engine_packet_t data_in;
  logic           result_valid;
  engine_packet_t result_out;
  logic           resp_valid;
  logic [31:0]    rd_data;

  int unsigned    cycle = 0;
  stim_row_t      live_cfg;
  logic [31:0]    shadow [`ENGINE_MEM_DEPTH];
  res_exp_t       res_q [$];
  rd_exp_t        rd_q [$];

  tb_clock_gen u_clock_gen (
    .ap_clk (ap_clk),
    .rst_n  (rst_n)
  );

  engine_read_write_top DUT (
    .ap_clk       (ap_clk),
    .rst_n        (rst_n),
    .cfg_we       (cfg_we),
    .cfg_addr     (cfg_addr),
    .cfg_wdata    (cfg_wdata),
    .in_valid     (in_valid),
    .data_in      (data_in),
    .result_valid (result_valid),
    .result_out   (result_out),
    .resp_valid   (resp_valid),
    .rd_data      (rd_data)
  );

  // --------------------------------------------------
  // Reference model
  // --------------------------------------------------

  // Per lane, scan from the top select bit down; no bit gives zero
  function automatic engine_packet_t route_lanes(logic [15:0] ops, engine_packet_t pkt);
    engine_packet_t lanes;
    logic [3:0]     sel;
    lanes = '0;
    for (int i = 0; i < `ENGINE_NUM_FIELDS; i++) begin
      sel = ops[4*i +: 4];
      for (int j = 3; j >= 0; j--) begin
        if (sel[j]) begin
          lanes.field[i] = pkt.field[j];
          break;
        end
      end
    end
    return lanes;
  endfunction

  // Base plus lane 1 (constant if forced), then shifted
  function automatic logic [31:0] calc_offset(stim_row_t cfg, logic [31:0] lane1_routed);
    logic [31:0] lane1;
    logic [31:0] sum;
    lane1 = cfg.cmask[1] ? {24'h0, cfg.cval} : lane1_routed;
    sum   = {24'h0, cfg.idx} + lane1;
    return cfg.dir ? (sum << cfg.gran) : (sum >> cfg.gran);
  endfunction

  // --------------------------------------------------
  // Error report, timeout and output monitor
  // --------------------------------------------------
  task automatic report_mismatch(string msg);
    $display("error at %0d ns: %s", $time, msg);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopping at first error");
  endtask

  always @(posedge ap_clk) begin
    cycle <= cycle + 1;
    if (cycle >= CYCLE_LIMIT) begin
      $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("*** TEST FAILED ***");
      $fatal(1, "simulation timeout");
    end
  end

  // Each result must show up exactly in its due cycle, in order
  task automatic check_result();
    res_exp_t exp_res;
    if (result_valid) begin
      assert (res_q.size() != 0)
        else report_mismatch("result_valid high with no packet in flight");
      exp_res = res_q.pop_front();
      assert (exp_res.due == cycle)
        else report_mismatch($sformatf("result in cycle %0d, due in cycle %0d",
                                       cycle, exp_res.due));
      assert (result_out == exp_res.pkt)
        else report_mismatch($sformatf("result_out %h, expected %h",
                                       result_out, exp_res.pkt));
    end else if (res_q.size() != 0) begin
      assert (res_q[0].due != cycle)
        else report_mismatch("result_valid missing in its due cycle");
    end
  endtask

  // Writes never answer, reads answer one cycle after the result
  task automatic check_response();
    rd_exp_t exp_rd;
    if (resp_valid) begin
      assert (rd_q.size() != 0)
        else report_mismatch("resp_valid high with no read in flight");
      exp_rd = rd_q.pop_front();
      assert (exp_rd.due == cycle)
        else report_mismatch($sformatf("response in cycle %0d, due in cycle %0d",
                                       cycle, exp_rd.due));
      assert (rd_data == exp_rd.data)
        else report_mismatch($sformatf("rd_data %h, expected %h", rd_data, exp_rd.data));
    end else if (rd_q.size() != 0) begin
      assert (rd_q[0].due != cycle)
        else report_mismatch("resp_valid missing in its due cycle");
    end
  endtask

  // Registered outputs checked at the falling edge
  always @(negedge ap_clk) begin
    if (!rst_n) begin
      assert (!result_valid && !resp_valid)
        else report_mismatch("valid strobe high during reset");
    end else begin
      check_result();
      check_response();
    end
  end

  // --------------------------------------------------
  // Stimulus
  // --------------------------------------------------

  // Inputs change 1 ns after the rising edge; strobes drop by default
  task automatic wait_drive_slot();
    @(posedge ap_clk);
    #1;
    cfg_we   = 1'b0;
    in_valid = 1'b0;
  endtask

  task automatic write_cfg(logic [1:0] addr, cfg_word_u word);
    wait_drive_slot();
    cfg_we    = 1'b1;
    cfg_addr  = addr;
    cfg_wdata = word;
  endtask

  task automatic apply_config(stim_row_t row);
    cfg_word_u word;
    word = '0;
    word.ctrl_word.ops_mask    = row.ops;
    word.ctrl_word.const_mask  = row.cmask;
    word.ctrl_word.granularity = row.gran;
    word.ctrl_word.direction   = row.dir;
    word.ctrl_word.write_mode  = row.wr;
    word.ctrl_word.id_channel  = 4'h3;
    word.ctrl_word.id_buffer   = 3'h5;
    write_cfg(`ENGINE_CFG_ADDR_CTRL, word);
    word.value_word = {24'h0, row.cval};
    write_cfg(`ENGINE_CFG_ADDR_CONST, word);
    word.value_word = {24'h0, row.idx};
    write_cfg(`ENGINE_CFG_ADDR_INDEX, word);
    live_cfg = row;
  endtask

  // Builds one packet, predicts its result and buffer effect, pulses in_valid
  task automatic send_packet(stim_row_t row);
    engine_packet_t pkt;
    engine_packet_t routed;
    logic [31:0]    off;
    for (int j = 0; j < `ENGINE_NUM_FIELDS; j++) begin
      pkt.field[j] = row.fix[j] ? {24'h0, row.fval} : $urandom();
    end
    routed = route_lanes(live_cfg.ops, pkt);
    off    = calc_offset(live_cfg, routed.field[1]);
    assert (off[31:8] == '0 && off[7:0] == row.exp_off)
      else report_mismatch($sformatf("table offset %h disagrees with model %h",
                                     row.exp_off, off));
    wait_drive_slot();
    in_valid = 1'b1;
    data_in  = pkt;
    res_q.push_back('{cycle + 3, routed});
    if (live_cfg.wr) begin
      shadow[off[7:0]] = routed.field[0];
    end else begin
      rd_q.push_back('{cycle + 4, shadow[off[7:0]]});
    end
  endtask

  initial begin
    void'($urandom(16));
    cfg_we    = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    in_valid  = 1'b0;
    data_in   = '0;
    live_cfg  = '0;
    for (int k = 0; k < `ENGINE_MEM_DEPTH; k++) begin
      shadow[k] = '0;
    end
    @(posedge rst_n);

    for (int r = 0; r < NUM_ROWS; r++) begin
      if (stim_table[r].do_cfg) begin
        apply_config(stim_table[r]);
      end
      repeat (stim_table[r].burst ? 4 : 1) begin
        send_packet(stim_table[r]);
      end
      wait_drive_slot();
      // Drain before touching configuration again
      while (res_q.size() != 0 || rd_q.size() != 0) begin
        @(posedge ap_clk);
      end
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule : tb_engine_read_write
